/* filelist.f */
+incdir+hw
+incdir+verif
hw/audio_pkg.sv
hw/cd_mixer.sv
hw/system_mixer.sv
hw/dynamic_compressor.sv
hw/audio_mix_top.sv
verif/tb_audio_mix.sv

/* verif/audio_ref_model.svh */
`ifndef AUDIO_REF_MODEL_SVH
`define AUDIO_REF_MODEL_SVH

`include "audio_params.svh"

//////////////////////////////////////////////////
// Expected values for the audio path
//////////////////////////////////////////////////

// Gated sum of the two CD sources, each at half level
function automatic int ref_cd(input int pcm, input int cdda, input bit e_pcm, input bit e_cdda);
	return (e_pcm ? (pcm >>> 1) : 0) + (e_cdda ? (cdda >>> 1) : 0);
endfunction

function automatic int ref_mix(input int gen, input int pcm, input int cdda,
	input bit e_pcm, input bit e_cdda, input bit c_ext);
	int cd;
	cd = ref_cd(pcm, cdda, e_pcm, e_cdda);
	return c_ext ? gen : (gen >>> 1) + (cd >>> 1);   // Console alone when CD is external
endfunction

function automatic int ref_compress(input int s, input comp_mode_t mode);
	int mag;
	int y;
	if (mode == COMP_OFF) begin
		return s;
	end
	mag = (s < 0) ? -s : s;
	if (mag > 32767) begin
		mag = 32767;
	end
	if (mode == COMP_SOFT) begin
		y = (mag < `COMP1_KNEE) ? mag * `COMP1_GAIN
			: (mag - `COMP1_KNEE) / `COMP1_FACTOR + `COMP1_BASE;
	end else begin   // Both hard settings share curve two
		y = (mag < `COMP2_KNEE) ? mag * `COMP2_GAIN
			: (mag - `COMP2_KNEE) / `COMP2_FACTOR + `COMP2_BASE;
	end
	if (y > 32767) begin
		y = 32767;
	end
	return (s < 0) ? -y : y;
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

/* verif/tb_audio_mix.sv */
`timescale 1ns/1ps

`include "audio_params.svh"

module tb_audio_mix import audio_pkg::*; ();

	localparam int WAIT_LIMIT = 20;
	localparam int STREAM_LEN = 40;
	localparam int LATENCY    = 3;   // Cycles from strobe to output

	logic       clk_sys;
	logic       reset;
	logic       in_valid;
	sample_t    gen_l, gen_r;
	sample_t    pcm_l, pcm_r;
	sample_t    cdda_l, cdda_r;
	logic       en_pcm, en_cdda, cd_external;
	comp_mode_t comp_mode;
	logic       out_valid;
	sample_t    out_l, out_r;

	int          cycle_cnt;
	int          test_errs;
	int          pass_count;
	int          fail_count;
	logic [31:0] rng_state;

	`include "audio_ref_model.svh"

	always #10 clk_sys = ~clk_sys;   // 20 ns period

	always @(posedge clk_sys) cycle_cnt <= cycle_cnt + 1;

	audio_mix_top u_audio_mix_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.in_valid    (in_valid),
		.gen_l       (gen_l),
		.gen_r       (gen_r),
		.pcm_l       (pcm_l),
		.pcm_r       (pcm_r),
		.cdda_l      (cdda_l),
		.cdda_r      (cdda_r),
		.en_pcm      (en_pcm),
		.en_cdda     (en_cdda),
		.cd_external (cd_external),
		.comp_mode   (comp_mode),
		.out_valid   (out_valid),
		.out_l       (out_l),
		.out_r       (out_r)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic drive_sample(input int g_l, g_r, p_l, p_r, c_l, c_r,
		input bit e_pcm, e_cdda, c_ext, input comp_mode_t mode);
		@(posedge clk_sys);
		in_valid    <= 1'b1;
		gen_l       <= sample_t'(g_l);
		gen_r       <= sample_t'(g_r);
		pcm_l       <= sample_t'(p_l);
		pcm_r       <= sample_t'(p_r);
		cdda_l      <= sample_t'(c_l);
		cdda_r      <= sample_t'(c_r);
		en_pcm      <= e_pcm;
		en_cdda     <= e_cdda;
		cd_external <= c_ext;
		comp_mode   <= mode;
	endtask

	// Sampled on the falling edge, away from register updates
	task automatic wait_output(output bit seen);
		int waits;
		waits = 0;
		@(negedge clk_sys);
		while (out_valid !== 1'b1 && waits < WAIT_LIMIT) begin
			@(negedge clk_sys);
			waits++;
		end
		seen = (out_valid === 1'b1);
		if (!seen) begin
			$display("Timeout at %0t: no out_valid within %0d cycles", $time, WAIT_LIMIT);
			test_errs++;
		end
	endtask

	task automatic compare_outputs(input int exp_l, input int exp_r);
		if (int'(out_l) != exp_l) begin
			$display("MISMATCH at %0t: out_l expected %0d, got %0d", $time, exp_l, out_l);
			test_errs++;
		end
		if (int'(out_r) != exp_r) begin
			$display("MISMATCH at %0t: out_r expected %0d, got %0d", $time, exp_r, out_r);
			test_errs++;
		end
	endtask

	task automatic run_sample(input int g_l, g_r, p_l, p_r, c_l, c_r,
		input bit e_pcm, e_cdda, c_ext, input comp_mode_t mode);
		int exp_l;
		int exp_r;
		bit seen;
		exp_l = ref_compress(ref_mix(g_l, p_l, c_l, e_pcm, e_cdda, c_ext), mode);
		exp_r = ref_compress(ref_mix(g_r, p_r, c_r, e_pcm, e_cdda, c_ext), mode);
		drive_sample(g_l, g_r, p_l, p_r, c_l, c_r, e_pcm, e_cdda, c_ext, mode);
		@(posedge clk_sys);
		in_valid <= 1'b0;
		wait_output(seen);
		if (seen) begin
			compare_outputs(exp_l, exp_r);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic reset_quiet();
		for (int i = 0; i < 9; i++) begin
			@(negedge clk_sys);
			if (out_valid !== 1'b0) begin
				$display("out_valid not low during reset at %0t", $time);
				test_errs++;
			end
		end
		@(posedge clk_sys);
		reset <= 1'b0;   // Tenth edge still sees reset high
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			if (out_valid !== 1'b0) begin
				$display("out_valid high without a strobe at %0t", $time);
				test_errs++;
			end
		end
		finish_test("reset_quiet");
	endtask

	task automatic plain_mix();
		run_sample(-3, 1001, -5, -777, 7, 3, 1'b1, 1'b1, 1'b0, COMP_OFF);
		run_sample(-32768, 32767, -32768, 32767, -32767, 32767, 1'b1, 1'b1, 1'b0, COMP_OFF);
		run_sample(12345, -12345, -1, 1, -1, 1, 1'b1, 1'b1, 1'b0, COMP_OFF);
		finish_test("plain_mix");
	endtask

	task automatic enable_routing();
		logic [2:0] c;
		for (int i = 0; i < 8; i++) begin
			c = 3'(i);   // en_pcm, en_cdda, cd_external
			run_sample(-9001, 4321, 20001, -15003, -7777, 9999, c[2], c[1], c[0], COMP_OFF);
			if (c[0]) begin
				compare_outputs(-9001, 4321);
			end
		end
		finish_test("enable_routing");
	endtask

	task automatic compression_curves();
		comp_mode_t modes[3];
		int         vals[9];
		int         knee;
		modes = '{COMP_SOFT, COMP_HARD, COMP_HARD_ALT};
		for (int m = 0; m < 3; m++) begin
			knee = (modes[m] == COMP_SOFT) ? `COMP1_KNEE : `COMP2_KNEE;
			vals = '{knee - 1, knee, knee + 1, 1 - knee, -knee, -knee - 1, 32767, -32767, -32768};
			// Console alone reaches the compressor unchanged
			for (int i = 0; i < 9; i++) begin
				run_sample(vals[i], vals[(i + 4) % 9], 0, 0, 0, 0, 1'b0, 1'b0, 1'b1, modes[m]);
			end
		end
		finish_test("compression_curves");
	endtask

	task automatic back_to_back_stream();
		int          q_l[$];
		int          q_r[$];
		int          q_cyc[$];
		int          smp[6];
		int          exp_cyc;
		logic [31:0] r;
		comp_mode_t  mode;
		bit          seen;
		fork
			begin
				for (int i = 0; i < STREAM_LEN; i++) begin
					for (int k = 0; k < 6; k++) begin
						r      = next_random();
						smp[k] = int'($signed(r[15:0]));
					end
					r    = next_random();
					mode = (i < STREAM_LEN / 2) ? COMP_OFF : COMP_SOFT;   // Switch mid-stream
					q_l.push_back(ref_compress(ref_mix(smp[0], smp[2], smp[4], r[0], r[1], r[2]), mode));
					q_r.push_back(ref_compress(ref_mix(smp[1], smp[3], smp[5], r[0], r[1], r[2]), mode));
					drive_sample(smp[0], smp[1], smp[2], smp[3], smp[4], smp[5], r[0], r[1], r[2], mode);
					q_cyc.push_back(cycle_cnt + 1);   // Counter not yet advanced on this edge
				end
				@(posedge clk_sys);
				in_valid <= 1'b0;
			end
			begin
				for (int n = 0; n < STREAM_LEN; n++) begin
					wait_output(seen);
					if (!seen) begin
						break;
					end
					exp_cyc = q_cyc.pop_front() + LATENCY;
					if (cycle_cnt != exp_cyc) begin
						$display("MISMATCH at %0t: out_valid cycle expected %0d, got %0d",
							$time, exp_cyc, cycle_cnt);
						test_errs++;
					end
					compare_outputs(q_l.pop_front(), q_r.pop_front());
				end
			end
		join
		for (int i = 0; i < 5; i++) begin
			@(negedge clk_sys);
			if (out_valid !== 1'b0) begin
				$display("Extra output after the stream at %0t", $time);
				test_errs++;
			end
		end
		finish_test("back_to_back_stream");
	endtask

	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		in_valid    = 1'b0;
		gen_l       = '0;
		gen_r       = '0;
		pcm_l       = '0;
		pcm_r       = '0;
		cdda_l      = '0;
		cdda_r      = '0;
		en_pcm      = 1'b0;
		en_cdda     = 1'b0;
		cd_external = 1'b0;
		comp_mode   = COMP_OFF;
		cycle_cnt   = 0;
		test_errs   = 0;
		pass_count  = 0;
		fail_count  = 0;
		rng_state   = 32'd31;
		reset_quiet();
		plain_mix();
		enable_routing();
		compression_curves();
		back_to_back_stream();
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* hw/audio_mix_top.sv */
`timescale 1ns/1ps

`include "audio_params.svh"

module audio_mix_top import audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       in_valid,
	input  sample_t    gen_l,
	input  sample_t    gen_r,
	input  sample_t    pcm_l,
	input  sample_t    pcm_r,
	input  sample_t    cdda_l,
	input  sample_t    cdda_r,
	input  logic       en_pcm,
	input  logic       en_cdda,
	input  logic       cd_external,
	input  comp_mode_t comp_mode,
	output logic       out_valid,
	output sample_t    out_l,
	output sample_t    out_r
);

	localparam int PIPE_DEPTH = 3;   // One register per stage

	logic       s1_valid;
	sample_t    s1_gen_l;
	sample_t    s1_gen_r;
	sample_t    s1_cd_l;
	sample_t    s1_cd_r;
	logic       s1_cd_external;
	comp_mode_t s1_mode;

	logic       s2_valid;
	sample_t    s2_mix_l;
	sample_t    s2_mix_r;
	comp_mode_t s2_mode;

	// Package word must agree with the compressor arithmetic
	if ($bits(sample_t) != `SAMPLE_W) begin : g_width_check
		$error("audio_mix_top: sample_t width differs from SAMPLE_W");
	end

	//////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////

	cd_mixer u_cd_mixer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.in_valid       (in_valid),
		.gen_l          (gen_l),
		.gen_r          (gen_r),
		.pcm_l          (pcm_l),
		.pcm_r          (pcm_r),
		.cdda_l         (cdda_l),
		.cdda_r         (cdda_r),
		.en_pcm         (en_pcm),
		.en_cdda        (en_cdda),
		.cd_external    (cd_external),
		.comp_mode      (comp_mode),
		.s1_valid       (s1_valid),
		.s1_gen_l       (s1_gen_l),
		.s1_gen_r       (s1_gen_r),
		.s1_cd_l        (s1_cd_l),
		.s1_cd_r        (s1_cd_r),
		.s1_cd_external (s1_cd_external),
		.s1_mode        (s1_mode)
	);

	system_mixer u_system_mixer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.s1_valid       (s1_valid),
		.s1_gen_l       (s1_gen_l),
		.s1_gen_r       (s1_gen_r),
		.s1_cd_l        (s1_cd_l),
		.s1_cd_r        (s1_cd_r),
		.s1_cd_external (s1_cd_external),
		.s1_mode        (s1_mode),
		.s2_valid       (s2_valid),
		.s2_mix_l       (s2_mix_l),
		.s2_mix_r       (s2_mix_r),
		.s2_mode        (s2_mode)
	);

	dynamic_compressor u_dynamic_compressor (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.s2_valid  (s2_valid),
		.s2_mix_l  (s2_mix_l),
		.s2_mix_r  (s2_mix_r),
		.s2_mode   (s2_mode),
		.out_valid (out_valid),
		.out_l     (out_l),
		.out_r     (out_r)
	);

	// Pipeline drains empty out of reset
	a_quiet_after_reset: assert property (
		@(posedge clk_sys)
		$fell(reset) |-> !out_valid [*PIPE_DEPTH]
	) else $error("audio_mix_top: out_valid too soon after reset");

endmodule

/* hw/dynamic_compressor.sv */
`timescale 1ns/1ps

`include "audio_params.svh"

module dynamic_compressor import audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       s2_valid,
	input  sample_t    s2_mix_l,
	input  sample_t    s2_mix_r,
	input  comp_mode_t s2_mode,
	output logic       out_valid,
	output sample_t    out_l,
	output sample_t    out_r
);

	// Largest positive level
	localparam int SAMPLE_MAX = (1 << (`SAMPLE_W - 1)) - 1;
	localparam int LVL_W      = `SAMPLE_W + 2;   // Room for level times 4

	sample_t cmp_l;
	sample_t cmp_r;

	//////////////////////////////////////////////////
	// Compression curve
	//////////////////////////////////////////////////

	function automatic sample_t compress(input sample_t s, input comp_mode_t mode);
		logic signed [`SAMPLE_W:0] sx;
		logic [`SAMPLE_W:0]        mag;
		logic [LVL_W-1:0]          lvl;
		logic [LVL_W-1:0]          y;
		sample_t                   res;

		sx  = s;                                   // Sign extend by one bit
		mag = s[`SAMPLE_W-1] ? (`SAMPLE_W+1)'(-sx) : (`SAMPLE_W+1)'(sx);

		// -32768 folds onto the top level
		if (mag > SAMPLE_MAX) begin
			lvl = LVL_W'(SAMPLE_MAX);
		end else begin
			lvl = LVL_W'(mag);
		end

		case (mode)
			COMP_SOFT: begin
				if (lvl < `COMP1_KNEE) begin
					y = LVL_W'(lvl * `COMP1_GAIN);        // Linear boost
				end else begin
					y = LVL_W'((lvl - `COMP1_KNEE) / `COMP1_FACTOR + `COMP1_BASE);
				end
			end
			default: begin                               // Both hard settings
				if (lvl < `COMP2_KNEE) begin
					y = LVL_W'(lvl * `COMP2_GAIN);
				end else begin
					y = LVL_W'((lvl - `COMP2_KNEE) / `COMP2_FACTOR + `COMP2_BASE);
				end
			end
		endcase

		// Top of either curve lands just past full scale
		if (y > SAMPLE_MAX) begin
			y = LVL_W'(SAMPLE_MAX);
		end

		res = sample_t'(y[`SAMPLE_W-1:0]);
		return s[`SAMPLE_W-1] ? -res : res;
	endfunction

	always_comb begin
		cmp_l = compress(s2_mix_l, s2_mode);
		cmp_r = compress(s2_mix_r, s2_mode);
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (s2_valid) begin
			if (s2_mode == COMP_OFF) begin
				out_l <= s2_mix_l;          // Bypass
				out_r <= s2_mix_r;
			end else begin
				out_l <= cmp_l;
				out_r <= cmp_r;
			end
		end
	end

	// One output per mixed sample, never early or late
	a_out_follows: assert property (
		@(posedge clk_sys) disable iff (reset)
		out_valid == $past(s2_valid)
	) else $error("dynamic_compressor: out_valid out of step with s2_valid");

endmodule

/* hw/system_mixer.sv */
`timescale 1ns/1ps

module system_mixer import audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       s1_valid,
	input  sample_t    s1_gen_l,
	input  sample_t    s1_gen_r,
	input  sample_t    s1_cd_l,
	input  sample_t    s1_cd_r,
	input  logic       s1_cd_external,
	input  comp_mode_t s1_mode,
	output logic       s2_valid,
	output sample_t    s2_mix_l,
	output sample_t    s2_mix_r,
	output comp_mode_t s2_mode
);

	sample_t avg_l;
	sample_t avg_r;

	//////////////////////////////////////////////////
	// Console and CD at equal weight
	//////////////////////////////////////////////////

	always_comb begin
		avg_l = (s1_gen_l >>> 1) + (s1_cd_l >>> 1);
		avg_r = (s1_gen_r >>> 1) + (s1_cd_r >>> 1);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	// CD routed elsewhere leaves the console at full level
	always_ff @(posedge clk_sys) begin
		if (s1_valid) begin
			if (s1_cd_external) begin
				s2_mix_l <= s1_gen_l;
				s2_mix_r <= s1_gen_r;
			end else begin
				s2_mix_l <= avg_l;
				s2_mix_r <= avg_r;
			end
			s2_mode <= s1_mode;
		end
	end

endmodule

/* hw/cd_mixer.sv */
`timescale 1ns/1ps

module cd_mixer import audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       in_valid,
	input  sample_t    gen_l,
	input  sample_t    gen_r,
	input  sample_t    pcm_l,
	input  sample_t    pcm_r,
	input  sample_t    cdda_l,
	input  sample_t    cdda_r,
	input  logic       en_pcm,
	input  logic       en_cdda,
	input  logic       cd_external,
	input  comp_mode_t comp_mode,
	output logic       s1_valid,
	output sample_t    s1_gen_l,
	output sample_t    s1_gen_r,
	output sample_t    s1_cd_l,
	output sample_t    s1_cd_r,
	output logic       s1_cd_external,
	output comp_mode_t s1_mode
);

	sample_t pcm_half_l;
	sample_t pcm_half_r;
	sample_t cdda_half_l;
	sample_t cdda_half_r;

	// Each CD source at half level, zero when muted
	always_comb begin
		pcm_half_l  = en_pcm  ? (pcm_l >>> 1)  : sample_t'(0);
		pcm_half_r  = en_pcm  ? (pcm_r >>> 1)  : sample_t'(0);
		cdda_half_l = en_cdda ? (cdda_l >>> 1) : sample_t'(0);
		cdda_half_r = en_cdda ? (cdda_r >>> 1) : sample_t'(0);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// Two halves never overflow the word
	always_ff @(posedge clk_sys) begin
		if (in_valid) begin
			s1_cd_l        <= pcm_half_l + cdda_half_l;
			s1_cd_r        <= pcm_half_r + cdda_half_r;
			s1_gen_l       <= gen_l;        // Console waits one stage
			s1_gen_r       <= gen_r;
			s1_cd_external <= cd_external;
			s1_mode        <= comp_mode;    // Travels with its sample
		end
	end

	// Mode register feeds the compressor two stages later
	a_mode_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		in_valid |-> !$isunknown(comp_mode)
	) else $error("cd_mixer: comp_mode unknown on strobe");

endmodule

/* hw/audio_pkg.sv */
package audio_pkg;

	//////////////////////////////////////////////////
	// Audio word and compressor setting
	//////////////////////////////////////////////////

	// Two's complement PCM word, same format for every source
	typedef logic signed [15:0] sample_t;

	// Setting of the output compressor
	typedef enum logic [1:0] {
		COMP_OFF      = 2'd0,  // Straight through
		COMP_SOFT     = 2'd1,
		COMP_HARD     = 2'd2,
		COMP_HARD_ALT = 2'd3   // Same curve as COMP_HARD
	} comp_mode_t;

endpackage

/* hw/audio_params.svh */
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Width of one audio word on every channel
`define SAMPLE_W 16

//////////////////////////////////////////////////
// Compressor curves
//////////////////////////////////////////////////

// Soft curve, 2x gain below the knee and 1/4 slope above
`define COMP1_FACTOR 4
`define COMP1_GAIN   2
`define COMP1_KNEE   14044   // 32767*3/7 + 1
`define COMP1_BASE   28088   // Knee times gain

// Hard curve, 4x gain below the knee and 1/8 slope above
`define COMP2_FACTOR 8
`define COMP2_GAIN   4
`define COMP2_KNEE   7400    // 32767*7/31 + 1
`define COMP2_BASE   29600   // Knee times gain

`endif
